//--- legv8_params.svh
// LEGv8 pipeline sizing constants
`ifndef LEGV8_PARAMS_SVH
`define LEGV8_PARAMS_SVH

// Data path and address width
`define LEGV8_XLEN 64

`define LEGV8_INSTR_W 32

// Register file geometry
`define LEGV8_REG_COUNT 32
`define LEGV8_REG_ADDR_W 5

// Hardwired zero register
`define LEGV8_ZR 31

`define LEGV8_PC_STEP 4

// D-format address offset
`define LEGV8_IMM_W 9

`endif

//--- legv8_pkg.sv
// LEGv8 pipeline types
// Opcodes, ALU operations, control bundle and stage register layouts
`include "legv8_params.svh"

package legv8_pkg;

  typedef enum logic [10:0] {
    OP_ADD  = 11'b10001011000,
    OP_SUB  = 11'b11001011000,
    OP_AND  = 11'b10001010000,
    OP_ORR  = 11'b10101010000,
    OP_LDUR = 11'b11111000010,
    OP_STUR = 11'b11111000000
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_ORR
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM, // From EX/MEM result
    FWD_WB   // From writeback value
  } fwd_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;    // Offset as second operand
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                        ctrl;
    logic [`LEGV8_XLEN-1:0]       rn_data;
    logic [`LEGV8_XLEN-1:0]       rm_data;
    logic [`LEGV8_XLEN-1:0]       imm;
    logic [`LEGV8_REG_ADDR_W-1:0] rn;
    logic [`LEGV8_REG_ADDR_W-1:0] rm;
    logic [`LEGV8_REG_ADDR_W-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    logic                         mem_read;
    logic                         mem_write;
    logic                         reg_write;
    logic                         mem_to_reg;
    logic [`LEGV8_XLEN-1:0]       alu_result;
    logic [`LEGV8_XLEN-1:0]       store_data;
    logic [`LEGV8_REG_ADDR_W-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic                         reg_write;
    logic                         mem_to_reg;
    logic [`LEGV8_XLEN-1:0]       alu_result;
    logic [`LEGV8_XLEN-1:0]       load_data;
    logic [`LEGV8_REG_ADDR_W-1:0] rd;
  } mem_wb_t;

endpackage

//--- legv8_decoder.sv
// LEGv8 decode logic
// Control fields, register numbers and sign-extended offset
`timescale 1ns/1ps
`include "legv8_params.svh"

module legv8_decoder import legv8_pkg::*; (
  input  logic [`LEGV8_INSTR_W-1:0]    instr,
  output ctrl_t                        ctrl,
  output logic [`LEGV8_REG_ADDR_W-1:0] rn,
  output logic [`LEGV8_REG_ADDR_W-1:0] rm,
  output logic [`LEGV8_REG_ADDR_W-1:0] rd,
  output logic [`LEGV8_XLEN-1:0]       imm
);

  opcode_e opcode;
  logic    is_store;

  assign opcode   = opcode_e'(instr[`LEGV8_INSTR_W-1 -: 11]);
  assign is_store = (opcode == OP_STUR);

  assign rn = instr[9:5];
  assign rd = instr[4:0];                              // Rt for loads and stores
  assign rm = is_store ? instr[4:0] : instr[20:16];    // Store data comes from Rt

  assign imm = {{(`LEGV8_XLEN - `LEGV8_IMM_W){instr[12 + `LEGV8_IMM_W - 1]}},
                instr[12 +: `LEGV8_IMM_W]};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    case (opcode)
      OP_ADD: begin
        ctrl.reg_write = 1'b1;
      end
      OP_SUB: begin
        ctrl.alu_op    = ALU_SUB;
        ctrl.reg_write = 1'b1;
      end
      OP_AND: begin
        ctrl.alu_op    = ALU_AND;
        ctrl.reg_write = 1'b1;
      end
      OP_ORR: begin
        ctrl.alu_op    = ALU_ORR;
        ctrl.reg_write = 1'b1;
      end
      OP_LDUR: begin
        ctrl.alu_src    = 1'b1;   // Address is base plus offset
        ctrl.mem_read   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_STUR: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      default: begin
        ctrl = '0;                // NOP
      end
    endcase
  end

endmodule

//--- legv8_regfile.sv
// LEGv8 register file
// Two read ports with write-first bypass, x31 hardwired to zero
`timescale 1ns/1ps
`include "legv8_params.svh"

module legv8_regfile (
  input  logic                         CLOCK,
  input  logic                         rst_n,
  input  logic [`LEGV8_REG_ADDR_W-1:0] rn,
  input  logic [`LEGV8_REG_ADDR_W-1:0] rm,
  output logic [`LEGV8_XLEN-1:0]       rn_data,
  output logic [`LEGV8_XLEN-1:0]       rm_data,
  input  logic                         wr_en,
  input  logic [`LEGV8_REG_ADDR_W-1:0] wr_rd,
  input  logic [`LEGV8_XLEN-1:0]       wr_data
);

  logic [`LEGV8_XLEN-1:0] regs [`LEGV8_REG_COUNT];

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `LEGV8_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_rd != `LEGV8_ZR)) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // Same-cycle writeback is visible to decode
  assign rn_data = (rn == `LEGV8_ZR)              ? '0      :
                   (wr_en && (wr_rd == rn))       ? wr_data : regs[rn];
  assign rm_data = (rm == `LEGV8_ZR)              ? '0      :
                   (wr_en && (wr_rd == rm))       ? wr_data : regs[rm];

endmodule

//--- legv8_hazard_unit.sv
// LEGv8 hazard unit
// Load-use stall and operand forwarding selects
`timescale 1ns/1ps
`include "legv8_params.svh"

module legv8_hazard_unit import legv8_pkg::*; (
  input  logic [`LEGV8_REG_ADDR_W-1:0] id_rn,
  input  logic [`LEGV8_REG_ADDR_W-1:0] id_rm,
  input  logic [`LEGV8_REG_ADDR_W-1:0] ex_rd,
  input  logic                         ex_mem_read,
  input  logic [`LEGV8_REG_ADDR_W-1:0] ex_rn,
  input  logic [`LEGV8_REG_ADDR_W-1:0] ex_rm,
  input  logic [`LEGV8_REG_ADDR_W-1:0] mem_rd,
  input  logic                         mem_reg_write,
  input  logic [`LEGV8_REG_ADDR_W-1:0] wb_rd,
  input  logic                         wb_reg_write,
  output logic                         stall,
  output fwd_sel_e                     fwd_a,
  output fwd_sel_e                     fwd_b
);

  logic mem_live;
  logic wb_live;

  // Writeback is checked first but yields when the newer EX/MEM value also matches
  function automatic fwd_sel_e pick(input logic mem_hit, input logic wb_hit);
    if (wb_hit && !mem_hit) begin
      return FWD_WB;
    end else if (mem_hit) begin
      return FWD_MEM;
    end
    return FWD_NONE;
  endfunction

  assign mem_live = mem_reg_write && (mem_rd != `LEGV8_ZR);
  assign wb_live  = wb_reg_write && (wb_rd != `LEGV8_ZR);

  assign fwd_a = pick(mem_live && (mem_rd == ex_rn), wb_live && (wb_rd == ex_rn));
  assign fwd_b = pick(mem_live && (mem_rd == ex_rm), wb_live && (wb_rd == ex_rm));

  // Loaded value not ready until MEM/WB
  assign stall = ex_mem_read && (ex_rd != `LEGV8_ZR) &&
                 ((ex_rd == id_rn) || (ex_rd == id_rm));

endmodule

//--- legv8_execute.sv
// LEGv8 execute stage
// Forwarding muxes, offset select and ALU
`timescale 1ns/1ps
`include "legv8_params.svh"

module legv8_execute import legv8_pkg::*; (
  input  id_ex_t                 id_ex,
  input  fwd_sel_e               fwd_a,
  input  fwd_sel_e               fwd_b,
  input  logic [`LEGV8_XLEN-1:0] mem_result,
  input  logic [`LEGV8_XLEN-1:0] wb_value,
  output logic [`LEGV8_XLEN-1:0] alu_result,
  output logic [`LEGV8_XLEN-1:0] store_data
);

  logic [`LEGV8_XLEN-1:0] op_a;
  logic [`LEGV8_XLEN-1:0] op_b_reg;
  logic [`LEGV8_XLEN-1:0] op_b;

  function automatic logic [`LEGV8_XLEN-1:0] operand(
    input fwd_sel_e               sel,
    input logic [`LEGV8_XLEN-1:0] reg_val,
    input logic [`LEGV8_XLEN-1:0] mem_val,
    input logic [`LEGV8_XLEN-1:0] wb_val
  );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign op_a     = operand(fwd_a, id_ex.rn_data, mem_result, wb_value);
  assign op_b_reg = operand(fwd_b, id_ex.rm_data, mem_result, wb_value);
  assign op_b     = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  assign store_data = op_b_reg;   // STUR data before offset select

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_ORR: alu_result = op_a | op_b;
      default: alu_result = op_a + op_b;
    endcase
  end

endmodule

//--- legv8_core.sv
// LEGv8 five-stage pipelined core
// PC, stage registers, stall and bubble handling, writeback select
`timescale 1ns/1ps
`include "legv8_params.svh"

module legv8_core import legv8_pkg::*; (
  input  logic                         CLOCK,
  input  logic                         rst_n,
  output logic [`LEGV8_XLEN-1:0]       imem_addr,
  input  logic [`LEGV8_INSTR_W-1:0]    imem_data,
  output logic [`LEGV8_XLEN-1:0]       dmem_addr,
  output logic [`LEGV8_XLEN-1:0]       dmem_wdata,
  output logic                         dmem_we,
  output logic                         dmem_re,
  input  logic [`LEGV8_XLEN-1:0]       dmem_rdata,
  output logic                         wb_valid,
  output logic [`LEGV8_REG_ADDR_W-1:0] wb_rd,
  output logic [`LEGV8_XLEN-1:0]       wb_data
);

  logic [`LEGV8_XLEN-1:0]       pc;
  logic [`LEGV8_INSTR_W-1:0]    if_id_instr;
  id_ex_t                       id_ex;
  id_ex_t                       id_ex_next;
  ex_mem_t                      ex_mem;
  mem_wb_t                      mem_wb;
  ctrl_t                        dec_ctrl;
  logic [`LEGV8_REG_ADDR_W-1:0] dec_rn;
  logic [`LEGV8_REG_ADDR_W-1:0] dec_rm;
  logic [`LEGV8_REG_ADDR_W-1:0] dec_rd;
  logic [`LEGV8_XLEN-1:0]       dec_imm;
  logic [`LEGV8_XLEN-1:0]       rn_data;
  logic [`LEGV8_XLEN-1:0]       rm_data;
  logic                         stall;
  fwd_sel_e                     fwd_a;
  fwd_sel_e                     fwd_b;
  logic [`LEGV8_XLEN-1:0]       alu_result;
  logic [`LEGV8_XLEN-1:0]       store_data;
  logic [`LEGV8_XLEN-1:0]       wb_value;

  // Fetch
  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= '0;
      if_id_instr <= '0;           // Zero word decodes as NOP
    end else if (!stall) begin
      pc          <= pc + `LEGV8_PC_STEP;
      if_id_instr <= imem_data;
    end
  end

  assign imem_addr = pc;

  // Decode
  legv8_decoder u_decoder (
    .instr (if_id_instr),
    .ctrl  (dec_ctrl),
    .rn    (dec_rn),
    .rm    (dec_rm),
    .rd    (dec_rd),
    .imm   (dec_imm)
  );

  legv8_regfile u_regfile (
    .CLOCK   (CLOCK),
    .rst_n   (rst_n),
    .rn      (dec_rn),
    .rm      (dec_rm),
    .rn_data (rn_data),
    .rm_data (rm_data),
    .wr_en   (mem_wb.reg_write),
    .wr_rd   (mem_wb.rd),
    .wr_data (wb_value)
  );

  legv8_hazard_unit u_hazard (
    .id_rn         (dec_rn),
    .id_rm         (dec_rm),
    .ex_rd         (id_ex.rd),
    .ex_mem_read   (id_ex.ctrl.mem_read),
    .ex_rn         (id_ex.rn),
    .ex_rm         (id_ex.rm),
    .mem_rd        (ex_mem.rd),
    .mem_reg_write (ex_mem.reg_write),
    .wb_rd         (mem_wb.rd),
    .wb_reg_write  (mem_wb.reg_write),
    .stall         (stall),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  always_comb begin
    id_ex_next.ctrl    = stall ? ctrl_t'('0) : dec_ctrl;   // Bubble on load-use
    id_ex_next.rn_data = rn_data;
    id_ex_next.rm_data = rm_data;
    id_ex_next.imm     = dec_imm;
    id_ex_next.rn      = dec_rn;
    id_ex_next.rm      = dec_rm;
    id_ex_next.rd      = dec_rd;
  end

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_next;
    end
  end

  // Execute
  legv8_execute u_execute (
    .id_ex      (id_ex),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (ex_mem.alu_result),
    .wb_value   (wb_value),
    .alu_result (alu_result),
    .store_data (store_data)
  );

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= store_data;
      ex_mem.rd         <= id_ex.rd;
    end
  end

  // Memory access, answered in the same cycle
  assign dmem_addr  = ex_mem.alu_result;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_we    = ex_mem.mem_write;
  assign dmem_re    = ex_mem.mem_read;

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= dmem_rdata;
      mem_wb.rd         <= ex_mem.rd;
    end
  end

  // Writeback
  assign wb_value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
  assign wb_valid = mem_wb.reg_write && (mem_wb.rd != `LEGV8_ZR);
  assign wb_rd    = mem_wb.rd;
  assign wb_data  = wb_value;

endmodule

//--- tb_legv8_core.sv
// Testbench for the LEGv8 five-stage core
// Directed and random programs checked against an in-order reference model
`timescale 1ns/1ps
`include "legv8_params.svh"

module tb_legv8_core import legv8_pkg::*; ();

  localparam int IMEM_DEPTH  = 64;
  localparam int DMEM_DEPTH  = 32;
  localparam int TAIL        = 4;    // Trailing NOPs per program
  localparam int RAND_LEN    = 40;
  localparam int NUM_RAND    = 3;
  localparam int DIR_LEN     = 30;   // Three directed programs together
  localparam int CYCLE_LIMIT = 20 + 2 * (DIR_LEN + NUM_RAND * RAND_LEN + (NUM_RAND + 3) * TAIL);

  logic                         CLOCK;
  logic                         rst_n;
  logic [`LEGV8_XLEN-1:0]       imem_addr;
  logic [`LEGV8_INSTR_W-1:0]    imem_data;
  logic [`LEGV8_XLEN-1:0]       dmem_addr;
  logic [`LEGV8_XLEN-1:0]       dmem_wdata;
  logic                         dmem_we;
  logic                         dmem_re;
  logic [`LEGV8_XLEN-1:0]       dmem_rdata;
  logic                         wb_valid;
  logic [`LEGV8_REG_ADDR_W-1:0] wb_rd;
  logic [`LEGV8_XLEN-1:0]       wb_data;

  logic [`LEGV8_INSTR_W-1:0]    imem    [IMEM_DEPTH];
  logic [`LEGV8_XLEN-1:0]       dmem    [DMEM_DEPTH];
  logic [`LEGV8_XLEN-1:0]       ref_mem [DMEM_DEPTH];
  opcode_e                      p_op    [IMEM_DEPTH];
  logic [`LEGV8_REG_ADDR_W-1:0] p_rd    [IMEM_DEPTH];
  logic [`LEGV8_REG_ADDR_W-1:0] p_rn    [IMEM_DEPTH];
  logic [`LEGV8_REG_ADDR_W-1:0] p_rm    [IMEM_DEPTH];
  logic [`LEGV8_IMM_W-1:0]      p_imm   [IMEM_DEPTH];
  logic [`LEGV8_REG_ADDR_W-1:0] exp_rd  [$];
  logic [`LEGV8_XLEN-1:0]       exp_val [$];
  int prog_len    = 0;
  int since_rst   = 0;
  int run_cycles  = 0;
  int wb_errors   = 0;
  int mem_errors  = 0;
  int misc_errors = 0;

  legv8_core uut (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  always #5 CLOCK = ~CLOCK;

  // Memories read combinationally and write on the rising edge
  assign imem_data  = (imem_addr < 4 * IMEM_DEPTH) ? imem[imem_addr[7:2]] : '0;
  assign dmem_rdata = dmem_re ? dmem[dmem_addr[4:0]] : '0;

  always @(posedge CLOCK) begin
    if (dmem_we) begin
      dmem[dmem_addr[4:0]] <= dmem_wdata;
    end
  end

  function automatic logic [`LEGV8_INSTR_W-1:0] encode(input int i);
    if (p_op[i] == OP_LDUR || p_op[i] == OP_STUR) begin
      return {p_op[i], p_imm[i], 2'b00, p_rn[i], p_rd[i]};   // D-format
    end
    return {p_op[i], p_rm[i], 6'b0, p_rn[i], p_rd[i]};
  endfunction

  // Architectural model, one instruction at a time
  function automatic void run_reference();
    logic [`LEGV8_XLEN-1:0] regs [`LEGV8_REG_COUNT];
    logic [`LEGV8_XLEN-1:0] a;
    logic [`LEGV8_XLEN-1:0] b;
    logic [`LEGV8_XLEN-1:0] addr;
    logic [`LEGV8_XLEN-1:0] res;
    exp_rd.delete();
    exp_val.delete();
    for (int r = 0; r < `LEGV8_REG_COUNT; r++) begin
      regs[r] = '0;
    end
    for (int w = 0; w < DMEM_DEPTH; w++) begin
      ref_mem[w] = w * 5;
    end
    for (int i = 0; i < prog_len; i++) begin
      a    = regs[p_rn[i]];
      b    = regs[p_rm[i]];
      addr = a + {{(`LEGV8_XLEN - `LEGV8_IMM_W){p_imm[i][`LEGV8_IMM_W-1]}}, p_imm[i]};
      res  = '0;
      case (p_op[i])
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_ORR:  res = a | b;
        OP_LDUR: res = ref_mem[addr[4:0]];
        default: ref_mem[addr[4:0]] = regs[p_rd[i]];     // Rt holds store data
      endcase
      if (p_op[i] != OP_STUR && p_rd[i] != `LEGV8_ZR) begin
        regs[p_rd[i]] = res;
        exp_rd.push_back(p_rd[i]);
        exp_val.push_back(res);
      end
    end
  endfunction

  task automatic push(input opcode_e op, input int rd, input int rn, input int rm, input int imm);
    p_op[prog_len]  = op;
    p_rd[prog_len]  = rd[4:0];
    p_rn[prog_len]  = rn[4:0];
    p_rm[prog_len]  = rm[4:0];
    p_imm[prog_len] = imm[8:0];
    prog_len++;
  endtask

  task automatic build_basic();
    prog_len = 0;
    for (int i = 1; i <= 4; i++) begin
      push(OP_LDUR, i, 31, 0, i);
    end
    push(OP_ADD, 5, 1, 2, 0);
    push(OP_SUB, 6, 3, 1, 0);
    push(OP_AND, 7, 3, 4, 0);
    push(OP_ORR, 8, 3, 4, 0);
  endtask

  task automatic build_forwarding();
    prog_len = 0;
    push(OP_LDUR, 1, 31, 0, 3);
    push(OP_ADD,  2, 1, 1, 0);     // Load-use
    push(OP_SUB,  3, 2, 1, 0);
    push(OP_ORR,  4, 3, 2, 0);
    push(OP_ADD,  6, 4, 3, 0);
    push(OP_ADD,  6, 6, 4, 0);
    push(OP_ADD,  7, 6, 6, 0);     // x6 live in both forward stages
    push(OP_AND,  8, 7, 6, 0);
    push(OP_LDUR, 9, 7, 0, -1);
    push(OP_ORR, 10, 9, 8, 0);
  endtask

  task automatic build_stores();
    prog_len = 0;
    push(OP_LDUR, 1, 31, 0, 2);
    push(OP_LDUR, 2, 31, 0, 7);
    push(OP_ADD,  3, 1, 2, 0);
    push(OP_STUR, 3, 31, 0, 12);
    push(OP_SUB, 31, 3, 1, 0);
    push(OP_ADD,  4, 31, 3, 0);    // x31 still reads zero
    push(OP_STUR, 4, 1, 0, -3);
    push(OP_LDUR, 5, 31, 0, 12);
    push(OP_ORR,  6, 5, 31, 0);
    push(OP_STUR, 31, 1, 0, 0);
    push(OP_LDUR, 31, 31, 0, 5);
    push(OP_ADD,  7, 31, 2, 0);
  endtask

  task automatic build_random();
    opcode_e op;
    int      rd;
    int      rn;
    int      rm;
    prog_len = 0;
    for (int i = 0; i < RAND_LEN; i++) begin
      case ($urandom_range(0, 5))
        0:       op = OP_ADD;
        1:       op = OP_SUB;
        2:       op = OP_AND;
        3:       op = OP_ORR;
        4:       op = OP_LDUR;
        default: op = OP_STUR;
      endcase
      rd = $urandom_range(0, 8);
      rn = $urandom_range(0, 3);
      rm = $urandom_range(0, 8);
      push(op, (rd == 8) ? 31 : rd, rn, (rm == 8) ? 31 : rm, $urandom_range(0, 511));
    end
  endtask

  task automatic run_program();
    @(negedge CLOCK);
    rst_n = 1'b0;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem[i] = (i < prog_len) ? encode(i) : '0;   // Zero word is a NOP
    end
    for (int w = 0; w < DMEM_DEPTH; w++) begin
      dmem[w] = w * 5;
    end
    run_reference();
    repeat (4) @(negedge CLOCK);
    rst_n = 1'b1;
    while (imem_addr != 4 * (prog_len + TAIL)) begin
      @(negedge CLOCK);
    end
    assert (exp_rd.size() == 0) else begin
      $display("%0d expected register writes never appeared", exp_rd.size());
      misc_errors++;
    end
    for (int w = 0; w < DMEM_DEPTH; w++) begin
      assert (dmem[w] == ref_mem[w]) else begin
        $display("FAILED dmem[%0d]: got %h expected %h", w, dmem[w], ref_mem[w]);
        mem_errors++;
      end
    end
  endtask

  // Writeback compare and quiet start after reset
  always @(posedge CLOCK) begin
    if (!rst_n) begin
      since_rst = 0;
    end else begin
      if (since_rst < 3) begin
        assert (!dmem_we && !dmem_re) else begin
          $display("Data memory strobe active %0d cycles after reset", since_rst);
          misc_errors++;
        end
      end
      if (since_rst < 4) begin
        assert (!wb_valid) else begin
          $display("Writeback seen %0d cycles after reset", since_rst);
          misc_errors++;
        end
      end
      if (wb_valid) begin
        assert (exp_rd.size() != 0) else begin
          $display("Unexpected writeback to x%0d", wb_rd);
          misc_errors++;
        end
        if (exp_rd.size() != 0) begin
          assert (wb_rd == exp_rd[0]) else begin
            $display("FAILED wb_rd: got %h expected %h", wb_rd, exp_rd[0]);
            wb_errors++;
          end
          assert (wb_data == exp_val[0]) else begin
            $display("FAILED wb_data: got %h expected %h", wb_data, exp_val[0]);
            wb_errors++;
          end
          void'(exp_rd.pop_front());
          void'(exp_val.pop_front());
        end
      end
      since_rst++;
    end
  end

  always @(posedge CLOCK) begin
    if (rst_n) begin
      run_cycles++;
    end
    if (run_cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    CLOCK = 1'b0;
    rst_n = 1'b0;
    void'($urandom(32'h6c1bacc9));
    build_basic();
    run_program();
    build_forwarding();
    run_program();
    build_stores();
    run_program();
    repeat (NUM_RAND) begin
      build_random();
      run_program();
    end
    $display("Errors: writeback %0d, memory %0d, other %0d", wb_errors, mem_errors, misc_errors);
    if (wb_errors + mem_errors + misc_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- legv8_core.f
+incdir+.
legv8_pkg.sv
legv8_decoder.sv
legv8_regfile.sv
legv8_hazard_unit.sv
legv8_execute.sv
legv8_core.sv
tb_legv8_core.sv
